//--- Bender.yml
package:
  name: usb_fs_phy

sources:
  - include_dirs:
      - common
    files:
      - common/usb_fs_pkg.sv
      - usb_tx/usb_tx_serializer.sv
      - usb_rx/usb_rx_deserializer.sv
      - hdl/usb_line_if.sv
      - hdl/usb_fs_phy.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/usb_tb_clock.sv
      - test/usb_fs_phy_tb.sv

//--- build.f
+incdir+common
common/usb_fs_pkg.sv
usb_tx/usb_tx_serializer.sv
usb_rx/usb_rx_deserializer.sv
hdl/usb_line_if.sv
hdl/usb_fs_phy.sv
test/usb_tb_clock.sv
test/usb_fs_phy_tb.sv

//--- common/usb_fs_params.svh
`ifndef USB_FS_PARAMS_SVH
`define USB_FS_PARAMS_SVH

// Clocks per bit, 48 MHz over 12 Mbit/s
`define USB_OVERSAMPLE 4

// Transmit FIFO entries, also the sender's initial credit count
`define USB_TX_DEPTH 2

// Ones in a row before a zero is stuffed
`define USB_STUFF_LIMIT 6

// SYNC byte, LSB first on the wire as KJKJKJKK
`define USB_SYNC_BYTE 8'h80

`endif

//--- common/usb_fs_pkg.sv
`default_nettype none

package usb_fs_pkg;

  // Line state of the un-flipped D+/D- pair
  typedef enum logic [1:0] {
    LS_SE0 = 2'd0,
    LS_J   = 2'd1,
    LS_K   = 2'd2,
    LS_SE1 = 2'd3
  } line_state_t;

  // How a receive packet ended
  typedef enum logic [1:0] {
    RX_NONE      = 2'd0,
    RX_EOP       = 2'd1,
    RX_STUFF_ERR = 2'd2
  } rx_cond_t;

  // Full speed: J is D+ high, D- low
  function automatic line_state_t decode_line_state(input logic dp, input logic dn);
    line_state_t ls;
    case ({dp, dn})
      2'b00:   ls = LS_SE0;
      2'b10:   ls = LS_J;
      2'b01:   ls = LS_K;
      default: ls = LS_SE1;
    endcase
    return ls;
  endfunction

endpackage

`default_nettype wire

//--- hdl/usb_fs_phy.sv
`timescale 1ns/1ns
`default_nettype none

module usb_fs_phy (
  input  logic                 clk_48MHz_i,
  input  logic                 arst_n,
  input  logic                 pin_flip,
  input  logic                 tx_valid,
  input  logic [7:0]           tx_data,
  input  logic                 tx_last,
  output logic                 tx_credit,
  output logic                 rx_valid,
  output logic [7:0]           rx_data,
  output logic                 rx_end,
  output usb_fs_pkg::rx_cond_t rx_cond,
  input  logic                 usb_dp_i,
  input  logic                 usb_dn_i,
  output logic                 usb_dp_o,
  output logic                 usb_dn_o,
  output logic                 usb_oe
);

  import usb_fs_pkg::*;

  // Transmit path to pads
  logic        tx_oe;
  logic        tx_j;
  logic        tx_se0;

  // Pads to receive path
  logic        rx_j;
  line_state_t rx_ls;
  logic        rx_gate;

  usb_tx_serializer i_usb_tx_serializer (
    .clk_48MHz_i (clk_48MHz_i),
    .arst_n      (arst_n),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_last     (tx_last),
    .tx_credit   (tx_credit),
    .tx_oe       (tx_oe),
    .tx_j        (tx_j),
    .tx_se0      (tx_se0)
  );

  usb_rx_deserializer i_usb_rx_deserializer (
    .clk_48MHz_i (clk_48MHz_i),
    .arst_n      (arst_n),
    .rx_j        (rx_j),
    .rx_ls       (rx_ls),
    .rx_gate     (rx_gate),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_end      (rx_end),
    .rx_cond     (rx_cond)
  );

  usb_line_if i_usb_line_if (
    .clk_48MHz_i (clk_48MHz_i),
    .arst_n      (arst_n),
    .pin_flip    (pin_flip),
    .tx_oe       (tx_oe),
    .tx_j        (tx_j),
    .tx_se0      (tx_se0),
    .usb_dp_i    (usb_dp_i),
    .usb_dn_i    (usb_dn_i),
    .usb_dp_o    (usb_dp_o),
    .usb_dn_o    (usb_dn_o),
    .usb_oe      (usb_oe),
    .rx_j        (rx_j),
    .rx_ls       (rx_ls),
    .rx_gate     (rx_gate)
  );

endmodule

`default_nettype wire

//--- hdl/usb_line_if.sv
`timescale 1ns/1ns
`default_nettype none

module usb_line_if (
  input  logic                    clk_48MHz_i,
  input  logic                    arst_n,
  input  logic                    pin_flip,
  input  logic                    tx_oe,
  input  logic                    tx_j,
  input  logic                    tx_se0,
  input  logic                    usb_dp_i,
  input  logic                    usb_dn_i,
  output logic                    usb_dp_o,
  output logic                    usb_dn_o,
  output logic                    usb_oe,
  output logic                    rx_j,
  output usb_fs_pkg::line_state_t rx_ls,
  output logic                    rx_gate
);

  import usb_fs_pkg::*;

  logic [1:0] dp_sync;
  logic [1:0] dn_sync;
  logic       dp_line;
  logic       dn_line;
  logic       j_hold;
  logic       diff_valid;

  // Drive side
  assign usb_oe   = tx_oe;
  assign usb_dp_o = tx_se0 ? 1'b0 : (tx_j ^ pin_flip);
  assign usb_dn_o = tx_se0 ? 1'b0 : (~tx_j ^ pin_flip);

  // Device must not hear its own transmission
  assign rx_gate = tx_oe;

  // Two-stage synchronizer on both pads
  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      dp_sync <= '0;
      dn_sync <= '0;
    end else begin
      dp_sync <= {dp_sync[0], usb_dp_i};
      dn_sync <= {dn_sync[0], usb_dn_i};
    end
  end

  // Undo the pin swap before decoding
  assign dp_line    = pin_flip ? dn_sync[1] : dp_sync[1];
  assign dn_line    = pin_flip ? dp_sync[1] : dn_sync[1];
  assign diff_valid = (dp_line != dn_line);

  assign rx_ls = decode_line_state(dp_line, dn_line);

  // SE0 and SE1 carry no differential value, keep the last one
  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      j_hold <= 1'b1;
    end else if (diff_valid) begin
      j_hold <= dp_line;
    end
  end

  assign rx_j = diff_valid ? dp_line : j_hold;

endmodule

`default_nettype wire

//--- test/usb_fs_phy_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_fs_params.svh"

module usb_fs_phy_tb;

  import usb_fs_pkg::*;

  localparam int BIT_CLKS   = `USB_OVERSAMPLE;
  localparam int WAIT_LIMIT = 4000;

  logic       clk_48MHz_i;
  logic       arst_n;
  logic       pin_flip;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       tx_last;
  logic       tx_credit;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       rx_end;
  rx_cond_t   rx_cond;
  logic       usb_dp_i;
  logic       usb_dn_i;
  logic       usb_dp_o;
  logic       usb_dn_o;
  logic       usb_oe;

  // Sender and scoreboard state
  int         credits;
  logic       pkt_first;
  logic [7:0] tx_exp [256];
  int         tx_total;
  logic       dec_valid;
  logic [7:0] dec_byte;
  logic [7:0] dec_expect;
  int         dec_count;
  int         dec_ones;
  logic       dec_done;
  logic [7:0] rx_exp [256];
  int         rx_total;
  int         rx_idx;
  int         rx_end_count;
  logic [7:0] rx_expect;
  rx_cond_t   exp_cond;
  logic       host_lvl;
  int         host_ones;
  logic       se0_pad;
  logic       j_pad;
  int         len;

  usb_tb_clock i_usb_tb_clock (
    .clk    (clk_48MHz_i),
    .arst_n (arst_n)
  );

  usb_fs_phy i_usb_fs_phy (
    .clk_48MHz_i (clk_48MHz_i),
    .arst_n      (arst_n),
    .pin_flip    (pin_flip),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_last     (tx_last),
    .tx_credit   (tx_credit),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_end      (rx_end),
    .rx_cond     (rx_cond),
    .usb_dp_i    (usb_dp_i),
    .usb_dn_i    (usb_dn_i),
    .usb_dp_o    (usb_dp_o),
    .usb_dn_o    (usb_dn_o),
    .usb_oe      (usb_oe)
  );

  assign rx_expect = rx_exp[rx_idx];
  assign se0_pad   = usb_oe && !usb_dp_o && !usb_dn_o;
  assign j_pad     = pin_flip ? (usb_dn_o && !usb_dp_o) : (usb_dp_o && !usb_dn_o);

  // Pads driven by the device also reach its own input buffers
  always @(posedge clk_48MHz_i) begin
    if (usb_oe) begin
      usb_dp_i <= usb_dp_o;
      usb_dn_i <= usb_dn_o;
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      credits      <= `USB_TX_DEPTH;
      rx_idx       <= 0;
      rx_end_count <= 0;
    end else begin
      credits <= credits + int'(tx_credit) - int'(tx_valid);
      if (rx_valid) begin
        rx_idx <= rx_idx + 1;
      end
      if (rx_end) begin
        rx_end_count <= rx_end_count + 1;
      end
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  a_reset_quiet: assert property (@(posedge clk_48MHz_i)
    $rose(arst_n) |-> !usb_oe && !tx_credit && !rx_valid && !rx_end
  ) else report_failure($sformatf(
    "Fail %0t usb_oe/tx_credit/rx_valid/rx_end got %b%b%b%b expected 0000",
    $time, $sampled(usb_oe), $sampled(tx_credit), $sampled(rx_valid), $sampled(rx_end)));

  a_credit_range: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    credits >= 0 && credits <= `USB_TX_DEPTH
  ) else report_failure($sformatf("Fail %0t credits got %0d expected 0 to %0d",
    $time, $sampled(credits), `USB_TX_DEPTH));

  a_oe_latency: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    tx_valid && pkt_first |-> !usb_oe ##1 !usb_oe ##1 usb_oe
  ) else report_failure("usb_oe did not rise exactly 2 cycles after the first tx_valid");

  a_tx_byte: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    dec_valid |-> dec_byte == dec_expect
  ) else report_failure($sformatf("Fail %0t usb_dp_o decoded byte got %02h expected %02h",
    $time, $sampled(dec_byte), $sampled(dec_expect)));

  a_tx_run: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    dec_ones <= `USB_STUFF_LIMIT
  ) else report_failure($sformatf("Fail %0t usb_dp_o run of ones got %0d expected <= %0d",
    $time, $sampled(dec_ones), `USB_STUFF_LIMIT));

  a_tx_count: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    dec_done |-> dec_count == tx_total
  ) else report_failure($sformatf("Fail %0t usb_dp_o byte count got %0d expected %0d",
    $time, $sampled(dec_count), $sampled(tx_total)));

  a_eop_shape: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    $rose(se0_pad) |-> se0_pad [*8] ##1 (j_pad && usb_oe) [*4] ##1 !usb_oe
  ) else report_failure("EOP on the pads is not 8 cycles of SE0 and 4 cycles of J");

  a_rx_byte: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    rx_valid |-> rx_data == rx_expect
  ) else report_failure($sformatf("Fail %0t rx_data got %02h expected %02h",
    $time, $sampled(rx_data), $sampled(rx_expect)));

  a_rx_cond: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    rx_end |-> rx_cond == exp_cond
  ) else report_failure($sformatf("Fail %0t rx_cond got %0d expected %0d",
    $time, $sampled(rx_cond), $sampled(exp_cond)));

  a_rx_count: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    rx_end |-> rx_idx == rx_total
  ) else report_failure($sformatf("Fail %0t rx_valid count got %0d expected %0d",
    $time, $sampled(rx_idx), $sampled(rx_total)));

  a_rx_gated: assert property (@(posedge clk_48MHz_i) disable iff (!arst_n)
    usb_oe |-> !rx_valid
  ) else report_failure("rx_valid pulsed while usb_oe was high");

  task automatic wait_for_reset();
    int n;
    n = 0;
    while (!arst_n) begin
      @(posedge clk_48MHz_i);
      n++;
      if (n > WAIT_LIMIT) report_failure("Timed out waiting for reset release");
    end
  endtask

  task automatic wait_for_oe(input logic level);
    int n;
    n = 0;
    while (usb_oe !== level) begin
      @(negedge clk_48MHz_i);
      n++;
      if (n > WAIT_LIMIT) report_failure("Timed out waiting for usb_oe to change");
    end
  endtask

  task automatic wait_for_credit();
    int n;
    n = 0;
    while (credits <= 0) begin
      @(posedge clk_48MHz_i);
      n++;
      if (n > WAIT_LIMIT) report_failure("Timed out waiting for a transmit credit");
    end
  endtask

  // Sender side of the credit protocol, one byte every other cycle at most
  task automatic send_tx_packet(input int n_bytes);
    tx_total  = n_bytes + 1;
    tx_exp[0] = `USB_SYNC_BYTE;
    for (int i = 0; i < n_bytes; i++) begin
      tx_exp[i + 1] = 8'($urandom);
    end
    // A byte of ones forces a stuffed zero in every packet
    tx_exp[n_bytes] = 8'hff;
    for (int i = 0; i < n_bytes; i++) begin
      wait_for_credit();
      tx_valid  <= 1'b1;
      tx_data   <= tx_exp[i + 1];
      tx_last   <= (i == n_bytes - 1);
      pkt_first <= (i == 0);
      @(posedge clk_48MHz_i);
      tx_valid  <= 1'b0;
      tx_last   <= 1'b0;
      pkt_first <= 1'b0;
      @(posedge clk_48MHz_i);
    end
  endtask

  // Host receiver, samples the pads near mid-bit on falling edges
  task automatic decode_tx_packet();
    logic       prev_lvl;
    logic       dp;
    logic       dn;
    logic       b;
    logic [7:0] acc;
    int         nbits;
    int         ones;
    logic       eop_seen;
    dec_count = 0;
    dec_ones  = 0;
    prev_lvl  = 1'b1;
    acc       = '0;
    nbits     = 0;
    ones      = 0;
    eop_seen  = 1'b0;
    wait_for_oe(1'b1);
    @(negedge clk_48MHz_i);
    for (int n = 0; n < 1000; n++) begin
      dp = pin_flip ? usb_dn_o : usb_dp_o;
      dn = pin_flip ? usb_dp_o : usb_dn_o;
      if (!dp && !dn) begin
        eop_seen = 1'b1;
        break;
      end
      // NRZI: unchanged level is a one
      b        = (dp == prev_lvl);
      prev_lvl = dp;
      if (ones == `USB_STUFF_LIMIT) begin
        ones = b ? ones + 1 : 0;
      end else begin
        ones  = b ? ones + 1 : 0;
        acc   = {b, acc[7:1]};
        nbits = nbits + 1;
        if (nbits == 8) begin
          dec_byte   = acc;
          dec_expect = tx_exp[dec_count];
          dec_valid  = 1'b1;
          dec_count  = dec_count + 1;
          nbits      = 0;
        end
      end
      dec_ones = ones;
      @(negedge clk_48MHz_i);
      dec_valid = 1'b0;
      repeat (BIT_CLKS - 1) @(negedge clk_48MHz_i);
    end
    if (!eop_seen) report_failure("No EOP seen at the end of the transmit packet");
    wait_for_oe(1'b0);
    dec_done = 1'b1;
    @(negedge clk_48MHz_i);
    dec_done = 1'b0;
  endtask

  task automatic drive_level(input logic lvl);
    usb_dp_i <= lvl ^ pin_flip;
    usb_dn_i <= ~lvl ^ pin_flip;
    repeat (BIT_CLKS) @(posedge clk_48MHz_i);
  endtask

  task automatic send_line_bit(input logic b);
    if (!b) host_lvl = ~host_lvl;
    host_ones = b ? host_ones + 1 : 0;
    drive_level(host_lvl);
  endtask

  task automatic send_line_byte(input logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      send_line_bit(v[i]);
      if (host_ones == `USB_STUFF_LIMIT) send_line_bit(1'b0);
    end
  endtask

  // Host transmitter, optionally breaking the stuffing rule before EOP
  task automatic send_rx_packet(input int n_bytes, input logic bad);
    int base;
    int ends_before;
    int n;
    base        = rx_total;
    ends_before = rx_end_count;
    for (int i = 0; i < n_bytes; i++) begin
      rx_exp[base + i] = 8'($urandom);
    end
    // Stuffed zeros must be dropped on receive
    rx_exp[base + n_bytes - 1] = 8'hff;
    rx_total  = base + n_bytes;
    exp_cond  = bad ? RX_STUFF_ERR : RX_EOP;
    host_lvl  = 1'b1;
    host_ones = 0;
    @(posedge clk_48MHz_i);
    send_line_byte(`USB_SYNC_BYTE);
    for (int i = 0; i < n_bytes; i++) begin
      send_line_byte(rx_exp[base + i]);
    end
    if (bad) begin
      send_line_bit(1'b0);
      repeat (7) drive_level(host_lvl);
    end
    usb_dp_i <= 1'b0;
    usb_dn_i <= 1'b0;
    repeat (2 * BIT_CLKS) @(posedge clk_48MHz_i);
    host_lvl = 1'b1;
    drive_level(host_lvl);
    n = 0;
    while (rx_end_count == ends_before) begin
      @(posedge clk_48MHz_i);
      n++;
      if (n > WAIT_LIMIT) report_failure("Timed out waiting for rx_end");
    end
  endtask

  initial begin
    void'($urandom(96640));
    pin_flip   = 1'b0;
    tx_valid   = 1'b0;
    tx_data    = '0;
    tx_last    = 1'b0;
    usb_dp_i   = 1'b1;
    usb_dn_i   = 1'b0;
    pkt_first  = 1'b0;
    dec_valid  = 1'b0;
    dec_byte   = '0;
    dec_expect = '0;
    dec_count  = 0;
    dec_ones   = 0;
    dec_done   = 1'b0;
    tx_total   = 0;
    rx_total   = 0;
    exp_cond   = RX_NONE;
    host_lvl   = 1'b1;
    host_ones  = 0;
    wait_for_reset();
    for (int flip = 0; flip < 2; flip++) begin
      @(posedge clk_48MHz_i);
      pin_flip <= (flip == 1);
      usb_dp_i <= (flip == 0);
      usb_dn_i <= (flip == 1);
      repeat (8) @(posedge clk_48MHz_i);
      len = 1 + int'($urandom % 6);
      fork
        send_tx_packet(len);
        decode_tx_packet();
      join
      send_rx_packet(1 + int'($urandom % 6), 1'b0);
      send_rx_packet(2, 1'b1);
    end
    repeat (8) @(posedge clk_48MHz_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/usb_tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module usb_tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for three rising edges, released away from the edge
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- usb_rx/usb_rx_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_fs_params.svh"

module usb_rx_deserializer (
  input  logic                    clk_48MHz_i,
  input  logic                    arst_n,
  input  logic                    rx_j,
  input  usb_fs_pkg::line_state_t rx_ls,
  input  logic                    rx_gate,
  output logic                    rx_valid,
  output logic [7:0]              rx_data,
  output logic                    rx_end,
  output usb_fs_pkg::rx_cond_t    rx_cond
);

  import usb_fs_pkg::*;

  localparam int TW           = $clog2(`USB_OVERSAMPLE);
  localparam int OW           = $clog2(`USB_STUFF_LIMIT + 1);
  localparam int SAMPLE_PHASE = `USB_OVERSAMPLE / 2;

  localparam logic [1:0] ST_HUNT  = 2'd0;
  localparam logic [1:0] ST_DATA  = 2'd1;
  localparam logic [1:0] ST_ABORT = 2'd2;

  logic          prev_j;
  logic [TW-1:0] phase;
  logic          last_j;
  logic [1:0]    state;
  logic [OW-1:0] ones;
  logic [2:0]    bit_cnt;
  logic [7:0]    shreg;

  logic          transition;
  logic          sample;
  logic          din;
  logic          at_limit;
  logic          take_bit;
  logic          byte_done;

  assign transition = (rx_j != prev_j);
  // Mid-bit, two clocks after the last edge
  assign sample     = (phase == TW'(SAMPLE_PHASE)) && !transition;
  // NRZI: no change is a one
  assign din        = (rx_j == last_j);
  assign at_limit   = (ones == OW'(`USB_STUFF_LIMIT));
  assign take_bit   = sample && !rx_gate && state == ST_DATA && rx_ls != LS_SE0 && !at_limit;
  assign byte_done  = take_bit && bit_cnt == 3'd7;

  always_ff @(posedge clk_48MHz_i) begin
    if (take_bit) begin
      shreg <= {din, shreg[7:1]};
    end
    if (byte_done) begin
      rx_data <= {din, shreg[7:1]};
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      prev_j   <= 1'b1;
      phase    <= '0;
      last_j   <= 1'b1;
      state    <= ST_HUNT;
      ones     <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_end   <= 1'b0;
      rx_cond  <= RX_NONE;
    end else begin
      prev_j   <= rx_j;
      rx_valid <= byte_done;
      rx_end   <= 1'b0;
      if (transition) begin
        phase <= TW'(1);
      end else begin
        phase <= (phase == TW'(`USB_OVERSAMPLE - 1)) ? '0 : phase + 1'b1;
      end
      if (sample) begin
        last_j <= rx_j;
      end
      if (rx_gate) begin
        state <= ST_HUNT;
      end else if (sample) begin
        case (state)
          ST_HUNT: begin
            // KK closes SYNC, and that last K counts as a one
            if (rx_ls == LS_K && !last_j) begin
              state   <= ST_DATA;
              ones    <= OW'(1);
              bit_cnt <= '0;
            end
          end
          ST_DATA: begin
            if (rx_ls == LS_SE0) begin
              rx_end  <= 1'b1;
              rx_cond <= RX_EOP;
              state   <= ST_HUNT;
            end else if (at_limit) begin
              if (din) begin
                rx_end  <= 1'b1;
                rx_cond <= RX_STUFF_ERR;
                state   <= ST_ABORT;
              end else begin
                ones <= '0;
              end
            end else begin
              ones    <= din ? ones + 1'b1 : '0;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          ST_ABORT: begin
            // Skip the rest of a broken packet up to its EOP
            if (rx_ls == LS_SE0) begin
              state <= ST_HUNT;
            end
          end
          default: state <= ST_HUNT;
        endcase
      end
    end
  end

  // Outputs lag the gate by a register, so the line must not turn around mid-byte
  a_rx_quiet_when_gated: assert property (
    @(posedge clk_48MHz_i) disable iff (!arst_n)
    rx_gate |-> !rx_valid && !rx_end
  ) else $error("receive output while transmitting");

endmodule

`default_nettype wire

//--- usb_tx/usb_tx_serializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "usb_fs_params.svh"

module usb_tx_serializer (
  input  logic       clk_48MHz_i,
  input  logic       arst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  input  logic       tx_last,
  output logic       tx_credit,
  output logic       tx_oe,
  output logic       tx_j,
  output logic       tx_se0
);

  localparam int DEPTH = `USB_TX_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);
  localparam int TW    = $clog2(`USB_OVERSAMPLE);
  localparam int OW    = $clog2(`USB_STUFF_LIMIT + 1);

  localparam logic [7:0] SYNC_PATTERN = `USB_SYNC_BYTE;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_SHIFT   = 2'd1;
  localparam logic [1:0] ST_EOP_SE0 = 2'd2;
  localparam logic [1:0] ST_EOP_J   = 2'd3;

  logic [7:0]    fifo_data [DEPTH];
  logic          fifo_last [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] fifo_cnt;
  logic          fifo_empty;
  logic          fifo_full;

  logic [1:0]    state;
  logic [TW-1:0] timer;
  logic [2:0]    bit_cnt;
  logic [7:0]    shreg;
  logic          cur_last;
  logic [OW-1:0] ones;

  logic          bit_end;
  logic          stuff_now;
  logic          pop;
  logic          emit;
  logic          emit_bit;

  assign fifo_empty = (fifo_cnt == '0);
  assign fifo_full  = (fifo_cnt == CW'(DEPTH));
  assign bit_end    = (timer == TW'(`USB_OVERSAMPLE - 1));
  assign stuff_now  = (ones == OW'(`USB_STUFF_LIMIT));

  assign tx_oe  = (state != ST_IDLE);
  assign tx_se0 = (state == ST_EOP_SE0);

  // Byte store, written on every accepted byte
  always_ff @(posedge clk_48MHz_i) begin
    if (tx_valid) begin
      fifo_data[wr_ptr] <= tx_data;
      fifo_last[wr_ptr] <= tx_last;
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fifo_cnt  <= '0;
      tx_credit <= 1'b0;
    end else begin
      if (tx_valid) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({tx_valid, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      // One credit back per byte moved into the shifter
      tx_credit <= pop;
    end
  end

  // Next bit on the wire, decided at the end of each bit time
  always_comb begin
    pop      = 1'b0;
    emit     = 1'b0;
    emit_bit = 1'b1;
    if (state == ST_IDLE && !fifo_empty) begin
      emit     = 1'b1;
      emit_bit = SYNC_PATTERN[0];
    end else if (state == ST_SHIFT && bit_end) begin
      if (stuff_now) begin
        emit     = 1'b1;
        emit_bit = 1'b0;
      end else if (bit_cnt != 3'd7) begin
        emit     = 1'b1;
        emit_bit = shreg[1];
      end else if (!cur_last && !fifo_empty) begin
        pop      = 1'b1;
        emit     = 1'b1;
        emit_bit = fifo_data[rd_ptr][0];
      end
    end
  end

  always_ff @(posedge clk_48MHz_i) begin
    if (state == ST_IDLE) begin
      shreg <= SYNC_PATTERN;
    end else if (pop) begin
      shreg <= fifo_data[rd_ptr];
    end else if (state == ST_SHIFT && bit_end && !stuff_now) begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      timer    <= '0;
      bit_cnt  <= '0;
      cur_last <= 1'b0;
      ones     <= '0;
      tx_j     <= 1'b1;
    end else begin
      timer <= (state == ST_IDLE || bit_end) ? '0 : timer + 1'b1;
      // NRZI: a zero toggles the level, a one holds it
      if (emit) begin
        tx_j <= emit_bit ? tx_j : ~tx_j;
        ones <= emit_bit ? ones + 1'b1 : '0;
      end
      case (state)
        ST_IDLE: begin
          bit_cnt  <= '0;
          cur_last <= 1'b0;
          if (!fifo_empty) begin
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (bit_end && !stuff_now) begin
            if (bit_cnt != 3'd7) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (pop) begin
              bit_cnt  <= '0;
              cur_last <= fifo_last[rd_ptr];
            end else begin
              // Last byte done or FIFO starved
              state   <= ST_EOP_SE0;
              bit_cnt <= '0;
              ones    <= '0;
            end
          end
        end
        ST_EOP_SE0: begin
          if (bit_end) begin
            if (bit_cnt == 3'd0) begin
              bit_cnt <= 3'd1;
            end else begin
              state <= ST_EOP_J;
              tx_j  <= 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Sender must hold a credit for every byte
  a_tx_credit_respected: assert property (
    @(posedge clk_48MHz_i) disable iff (!arst_n)
    tx_valid |-> !fifo_full
  ) else $error("tx_valid while transmit FIFO is full");

endmodule

`default_nettype wire
